/* all.f */
+incdir+verif
design/armIsaPkg.sv
design/pipeCtrlPkg.sv
design/alu.sv
design/regFile.sv
design/controller.sv
design/datapath.sv
design/hazardUnit.sv
design/armPipeTop.sv
verif/armPipeTb.sv

/* Bender.yml */
package:
  name: arm_pipe

sources:
  - design/armIsaPkg.sv
  - design/pipeCtrlPkg.sv
  - design/alu.sv
  - design/regFile.sv
  - design/controller.sv
  - design/datapath.sv
  - design/hazardUnit.sv
  - design/armPipeTop.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/armPipeTb.sv

/* verif/armRefModel.svh */
// Program image, model state and the expected store list
logic [31:0] progMem [0:63];
logic [31:0] refMem  [0:63];
logic [31:0] refRegs [0:15];
logic [3:0]  refFlags;
logic [31:0] expAddr [$];
logic [31:0] expData [$];
integer      seed = 32'h59a4_cb88;

// Body ends where the register dump starts
localparam int BodyEnd = 31;
// B to itself, always
localparam logic [31:0] HaltInstr = 32'hEAFF_FFFE;

// Different for every word address
function automatic logic [31:0] fillWord(input int addr);
  return 32'h3C5A_0000 ^ (addr * 32'h0001_0107);
endfunction

function automatic int randBelow(input int n);
  return int'($unsigned($random(seed)) % n);
endfunction

function automatic logic [3:0] randCond();
  if (randBelow(2) == 0) begin
    return condAl;
  end
  return 4'(randBelow(14));
endfunction

function automatic logic [31:0] encDp(input logic [3:0] cond, input dpOpcode op,
                                      input logic sBit, input logic [3:0] rn,
                                      input logic [3:0] rd, input logic isImm,
                                      input logic [11:0] op2);
  return {cond, 2'b00, isImm, op, sBit, rn, rd, op2};
endfunction

// Pre-indexed, offset added, no writeback
function automatic logic [31:0] encMem(input logic [3:0] cond, input logic load,
                                       input logic [3:0] rn, input logic [3:0] rd,
                                       input logic [11:0] offset);
  return {cond, 7'b0101100, load, rn, rd, offset};
endfunction

// 8-bit value rotated right by twice the rotate field
function automatic logic [31:0] rotImm(input logic [11:0] field);
  logic [31:0] base;
  int          amount;
  base   = {24'b0, field[7:0]};
  amount = 2 * field[11:8];
  return (base >> amount) | (base << (32 - amount));
endfunction

function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] f);
  logic n, z, c, v;
  n = f[FlagN];
  z = f[FlagZ];
  c = f[FlagC];
  v = f[FlagV];
  case (cond)
    condEq: return z;
    condNe: return !z;
    condCs: return c;
    condCc: return !c;
    condMi: return n;
    condPl: return !n;
    condVs: return v;
    condVc: return !v;
    condHi: return c && !z;
    condLs: return !c || z;
    condGe: return n == v;
    condLt: return n != v;
    condGt: return !z && (n == v);
    condLe: return z || (n != v);
    default: return 1'b1;
  endcase
endfunction

function automatic logic [31:0] randDp(input logic [3:0] cond);
  dpOpcode     op;
  logic        isImm;
  logic [11:0] op2;
  case (randBelow(6))
    0: op = opAdd;
    1: op = opSub;
    2: op = opAnd;
    3: op = opOrr;
    4: op = opMov;
    default: op = opCmp;
  endcase
  isImm = 1'(randBelow(2));
  op2   = isImm ? 12'(randBelow(4096)) : 12'(randBelow(8));
  return encDp(cond, op, (op == opCmp) || (randBelow(4) == 0),
               (op == opMov) ? 4'd0 : 4'(randBelow(8)),
               (op == opCmp) ? 4'd0 : 4'(randBelow(8)), isImm, op2);
endfunction

// Init R0-R7 and base R8, random body, dump of R0-R7, then halt
task automatic genProgram();
  int         idx;
  int         room;
  logic [3:0] rd;
  for (int i = 0; i < 64; i++) begin
    progMem[i] = 32'h0;
  end
  for (int r = 0; r < 8; r++) begin
    progMem[r] = encDp(condAl, opMov, 1'b0, 4'd0, 4'(r), 1'b1, 12'(randBelow(4096)));
  end
  progMem[8] = encDp(condAl, opMov, 1'b0, 4'd0, 4'd8, 1'b1, 12'h000);
  idx = 9;
  while (idx < BodyEnd) begin
    case (randBelow(8))
      0: begin
        // Load and an immediate use of its result
        rd = 4'(randBelow(8));
        progMem[idx] = encMem(condAl, 1'b1, 4'd8, rd, 12'(randBelow(48) * 4));
        idx++;
        if (idx < BodyEnd) begin
          progMem[idx] = encDp(condAl, opAdd, 1'b0, rd, 4'(randBelow(8)), 1'b0,
                               12'(randBelow(8)));
          idx++;
        end
      end
      1: begin
        progMem[idx] = encMem(randCond(), 1'b0, 4'd8, 4'(randBelow(8)),
                              12'(randBelow(48) * 4));
        idx++;
      end
      2: begin
        // Forward skip of 1 to 3, never past the dump
        room = BodyEnd - idx - 1;
        if (room > 0) begin
          progMem[idx] = {randCond(), 4'b1010, 24'(randBelow(room < 3 ? room : 3))};
        end else begin
          progMem[idx] = randDp(randCond());
        end
        idx++;
      end
      default: begin
        progMem[idx] = randDp(randCond());
        idx++;
      end
    endcase
  end
  for (int r = 0; r < 8; r++) begin
    progMem[BodyEnd + r] = encMem(condAl, 1'b0, 4'd8, 4'(r), 12'(192 + 4 * r));
  end
  progMem[BodyEnd + 8] = HaltInstr;
endtask

// Architectural run, one instruction at a time
task automatic runModel();
  int          pc;
  int          steps;
  logic [31:0] instr, srcA, srcB, res, addr;
  logic        carry, ovf;
  dpOpcode     op;
  for (int i = 0; i < 64; i++) begin
    refMem[i] = fillWord(i);
  end
  for (int r = 0; r < 16; r++) begin
    refRegs[r] = 32'h0;
  end
  refFlags = 4'b0000;
  pc       = 0;
  steps    = 0;
  while (progMem[pc / 4] != HaltInstr && steps < 500) begin
    instr = progMem[pc / 4];
    steps++;
    pc += 4;
    if (!condHolds(instr[31:28], refFlags)) begin
      continue;
    end
    case (instr[27:26])
      2'b00: begin
        op    = dpOpcode'(instr[24:21]);
        srcA  = refRegs[instr[19:16]];
        srcB  = instr[25] ? rotImm(instr[11:0]) : refRegs[instr[3:0]];
        carry = refFlags[FlagC];
        ovf   = refFlags[FlagV];
        case (op)
          opAdd: begin
            {carry, res} = {1'b0, srcA} + {1'b0, srcB};
            ovf = (srcA[31] == srcB[31]) && (res[31] != srcA[31]);
          end
          opSub, opCmp: begin
            res   = srcA - srcB;
            carry = (srcA >= srcB);
            ovf   = (srcA[31] != srcB[31]) && (res[31] != srcA[31]);
          end
          opAnd: res = srcA & srcB;
          opOrr: res = srcA | srcB;
          default: res = srcB;
        endcase
        if (op != opCmp) begin
          refRegs[instr[15:12]] = res;
        end
        if (instr[20] || op == opCmp) begin
          refFlags[FlagN] = res[31];
          refFlags[FlagZ] = (res == 32'h0);
          refFlags[FlagC] = carry;
          refFlags[FlagV] = ovf;
        end
      end
      2'b01: begin
        addr = refRegs[instr[19:16]] + instr[11:0];
        if (instr[20]) begin
          refRegs[instr[15:12]] = refMem[addr[7:2]];
        end else begin
          refMem[addr[7:2]] = refRegs[instr[15:12]];
          expAddr.push_back(addr);
          expData.push_back(refRegs[instr[15:12]]);
        end
      end
      default: begin
        // Target is the branch address plus 8 plus the offset
        pc = pc + 4 + int'({{6{instr[23]}}, instr[23:0], 2'b00});
      end
    endcase
  end
endtask

/* verif/armPipeTb.sv */
`timescale 1ns/1ps

module armPipeTb;
  import armIsaPkg::*;

  localparam int AddrW     = 16;
  localparam int HangLimit = 2000;

  logic             clk;
  logic             reset;
  logic [31:0]      InstrF;
  logic [31:0]      ReadDataM;
  logic [AddrW-1:0] PCF;
  logic             MemWriteM;
  logic [31:0]      ALUOutM;
  logic [31:0]      WriteDataM;

  logic [31:0] dataMem [0:63];
  int          errors;
  int          storesSeen;
  int          storesExpected;
  int          cycles;
  logic [31:0] wantAddr;
  logic [31:0] wantData;

  `include "armRefModel.svh"

  armPipeTop #(
    .AddrWidth (AddrW)
  ) uut (
    .clk        (clk),
    .reset      (reset),
    .InstrF     (InstrF),
    .ReadDataM  (ReadDataM),
    .PCF        (PCF),
    .MemWriteM  (MemWriteM),
    .ALUOutM    (ALUOutM),
    .WriteDataM (WriteDataM)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Pop the next expected store and compare, then update data memory
  task automatic checkStore();
    wantAddr = expAddr.pop_front();
    wantData = expData.pop_front();
    assert (ALUOutM === wantAddr) else begin
      $display("mismatch storeAddr%0d: expected %h, actual %h",
               storesSeen, wantAddr, ALUOutM);
      errors++;
    end
    assert (WriteDataM === wantData) else begin
      $display("mismatch storeData%0d: expected %h, actual %h",
               storesSeen, wantData, WriteDataM);
      errors++;
    end
    dataMem[ALUOutM[7:2]] = WriteDataM;
    storesSeen++;
  endtask

  // Memories answer mid-cycle, ahead of the next rising edge
  always @(negedge clk) begin
    if (!reset && MemWriteM === 1'b1) begin
      checkStore();
    end
    InstrF    <= progMem[PCF[7:2]];
    ReadDataM <= dataMem[ALUOutM[7:2]];
  end

  initial begin
    reset      = 1'b1;
    InstrF     = 32'h0;
    ReadDataM  = 32'h0;
    errors     = 0;
    storesSeen = 0;
    for (int i = 0; i < 64; i++) begin
      dataMem[i] = fillWord(i);
    end
    genProgram();
    runModel();
    storesExpected = expAddr.size();

    repeat (8) begin
      @(negedge clk);
      assert (MemWriteM === 1'b0) else begin
        $display("mismatch resetMemWrite: expected %b, actual %b", 1'b0, MemWriteM);
        errors++;
      end
    end
    // First fetch comes from address 0
    assert (PCF === '0) else begin
      $display("mismatch resetPc: expected %h, actual %h", {AddrW{1'b0}}, PCF);
      errors++;
    end
    reset = 1'b0;

    cycles = 0;
    while (storesSeen < storesExpected && cycles < HangLimit) begin
      @(posedge clk);
      cycles++;
    end
    assert (storesSeen >= storesExpected) else begin
      $display("processor hung: only %0d of %0d stores seen after %0d cycles",
               storesSeen, storesExpected, HangLimit);
      errors++;
    end

    $display("%0d of %0d stores checked, %0d errors", storesSeen, storesExpected, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* design/armPipeTop.sv */
`timescale 1ns/1ps

module armPipeTop #(
  parameter int AddrWidth = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [31:0]          InstrF,
  input  logic [31:0]          ReadDataM,
  output logic [AddrWidth-1:0] PCF,
  output logic                 MemWriteM,
  output logic [31:0]          ALUOutM,
  output logic [31:0]          WriteDataM
);
  import armIsaPkg::*;
  import pipeCtrlPkg::*;

  // Controller to datapath
  regSrc RegSrcD;
  immSrc ImmSrcD;
  aluOp  ALUControlE;
  logic  ALUSrcE, BranchTakenE, MemtoRegW, RegWriteW;

  // Controller to hazard unit
  logic  MemtoRegE, RegWriteM;

  // Datapath to controller
  logic [31:0] InstrD;
  logic [3:0]  ALUFlagsE;

  // Hazard detection and control
  logic  Match_1E_M, Match_1E_W, Match_2E_M, Match_2E_W, Match_12D_E;
  fwdSel ForwardAE, ForwardBE;
  logic  StallF, StallD, FlushD, FlushE;

  controller uController (.*);

  datapath #(
    .AddrWidth (AddrWidth)
  ) uDatapath (.*);

  hazardUnit uHazardUnit (.*);

endmodule

/* design/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
  input  logic               Match_1E_M,
  input  logic               Match_1E_W,
  input  logic               Match_2E_M,
  input  logic               Match_2E_W,
  input  logic               Match_12D_E,
  input  logic               RegWriteM,
  input  logic               RegWriteW,
  input  logic               MemtoRegE,
  input  logic               BranchTakenE,
  output pipeCtrlPkg::fwdSel ForwardAE,
  output pipeCtrlPkg::fwdSel ForwardBE,
  output logic               StallF,
  output logic               StallD,
  output logic               FlushD,
  output logic               FlushE
);
  import pipeCtrlPkg::*;

  logic ldrStall;

  // Memory stage wins over writeback
  function automatic fwdSel pickForward(input logic matchM, input logic matchW,
                                        input logic regWriteM, input logic regWriteW);
    if (matchM && regWriteM) begin
      return fwdMemory;
    end else if (matchW && regWriteW) begin
      return fwdWriteback;
    end
    return fwdNone;
  endfunction

  assign ForwardAE = pickForward(Match_1E_M, Match_1E_W, RegWriteM, RegWriteW);
  assign ForwardBE = pickForward(Match_2E_M, Match_2E_W, RegWriteM, RegWriteW);

  // Load in execute feeding the decode instruction
  assign ldrStall = Match_12D_E && MemtoRegE;

  assign StallF = ldrStall;
  assign StallD = ldrStall;
  assign FlushD = BranchTakenE;
  assign FlushE = ldrStall || BranchTakenE;

  // A load and a taken branch cannot share the execute stage
  always_comb begin
    stallFlushClash: assert final (!(StallD === 1'b1 && FlushD === 1'b1))
      else $error("hazardUnit: decode stalled and flushed together");
  end

endmodule

/* design/datapath.sv */
`timescale 1ns/1ps

module datapath #(
  parameter int AddrWidth = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  pipeCtrlPkg::regSrc   RegSrcD,
  input  pipeCtrlPkg::immSrc   ImmSrcD,
  input  logic                 ALUSrcE,
  input  armIsaPkg::aluOp      ALUControlE,
  input  logic                 BranchTakenE,
  input  logic                 MemtoRegW,
  input  logic                 RegWriteW,
  input  logic [31:0]          InstrF,
  input  logic [31:0]          ReadDataM,
  input  pipeCtrlPkg::fwdSel   ForwardAE,
  input  pipeCtrlPkg::fwdSel   ForwardBE,
  input  logic                 StallF,
  input  logic                 StallD,
  input  logic                 FlushD,
  input  logic                 FlushE,
  output logic [AddrWidth-1:0] PCF,
  output logic [31:0]          InstrD,
  output logic [3:0]           ALUFlagsE,
  output logic [31:0]          ALUOutM,
  output logic [31:0]          WriteDataM,
  output logic                 Match_1E_M,
  output logic                 Match_1E_W,
  output logic                 Match_2E_M,
  output logic                 Match_2E_W,
  output logic                 Match_12D_E
);
  import pipeCtrlPkg::*;

  logic [AddrWidth-1:0] pcPlus4F, pcNextF;
  logic [31:0] rd1D, rd2D, imm8D, extImmD;
  logic [63:0] rotPairD;
  logic [3:0]  ra1D, ra2D, wa3D;
  logic [31:0] rd1E, rd2E, extImmE, srcAE, srcBE, writeDataE, aluResultE;
  logic [3:0]  ra1E, ra2E, wa3E, wa3M, wa3W;
  logic [31:0] aluOutW, readDataW, ResultW;

  function automatic logic [31:0] bypass(input fwdSel sel, input logic [31:0] regVal,
                                         input logic [31:0] memVal, input logic [31:0] wbVal);
    case (sel)
      fwdMemory:    return memVal;
      fwdWriteback: return wbVal;
      default:      return regVal;
    endcase
  endfunction

  // Fetch
  assign pcPlus4F = PCF + AddrWidth'(4);
  assign pcNextF  = BranchTakenE ? aluResultE[AddrWidth-1:0] : pcPlus4F;

  always_ff @(posedge clk) begin
    if (reset) begin
      PCF <= '0;
    end else if (!StallF) begin
      PCF <= pcNextF;
    end
  end

  // Decode
  always_ff @(posedge clk) begin
    if (reset || FlushD) begin
      InstrD <= '0;
    end else if (!StallD) begin
      InstrD <= InstrF;
    end
  end

  assign ra1D = RegSrcD[RegSrcPcA] ? 4'd15 : InstrD[19:16];
  assign ra2D = RegSrcD[RegSrcRdB] ? InstrD[15:12] : InstrD[3:0];
  assign wa3D = InstrD[15:12];

  // PC+4 in fetch equals PC+8 of the decode instruction
  regFile uRegFile (
    .clk         (clk),
    .WriteEnable (RegWriteW),
    .ReadAddr1   (ra1D),
    .ReadAddr2   (ra2D),
    .WriteAddr   (wa3W),
    .WriteData   (ResultW),
    .PCPlus8     (32'(pcPlus4F)),
    .ReadData1   (rd1D),
    .ReadData2   (rd2D)
  );

  // Rotate right by twice the 4-bit rotate field
  assign imm8D    = {24'b0, InstrD[7:0]};
  assign rotPairD = {imm8D, imm8D} >> {InstrD[11:8], 1'b0};

  always_comb begin
    case (ImmSrcD)
      immOffset12: extImmD = {20'b0, InstrD[11:0]};
      immBranch24: extImmD = {{6{InstrD[23]}}, InstrD[23:0], 2'b00};
      default:     extImmD = rotPairD[31:0];
    endcase
  end

  // Execute
  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    extImmE <= extImmD;
  end

  always_ff @(posedge clk) begin
    if (reset || FlushE) begin
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
    end else begin
      ra1E <= ra1D;
      ra2E <= ra2D;
      wa3E <= wa3D;
    end
  end

  assign srcAE      = bypass(ForwardAE, rd1E, ALUOutM, ResultW);
  assign writeDataE = bypass(ForwardBE, rd2E, ALUOutM, ResultW);
  assign srcBE      = ALUSrcE ? extImmE : writeDataE;

  alu uAlu (
    .SrcA       (srcAE),
    .SrcB       (srcBE),
    .ALUControl (ALUControlE),
    .Result     (aluResultE),
    .Flags      (ALUFlagsE)
  );

  // Memory
  always_ff @(posedge clk) begin
    ALUOutM    <= aluResultE;
    WriteDataM <= writeDataE;
    wa3M       <= wa3E;
  end

  // Writeback
  always_ff @(posedge clk) begin
    aluOutW   <= ALUOutM;
    readDataW <= ReadDataM;
    wa3W      <= wa3M;
  end

  assign ResultW = MemtoRegW ? readDataW : aluOutW;

  // Register-number matches for the hazard unit
  assign Match_1E_M  = (wa3M == ra1E);
  assign Match_1E_W  = (wa3W == ra1E);
  assign Match_2E_M  = (wa3M == ra2E);
  assign Match_2E_W  = (wa3W == ra2E);
  assign Match_12D_E = (wa3E == ra1D) || (wa3E == ra2D);

endmodule

/* design/controller.sv */
`timescale 1ns/1ps

module controller (
  input  logic                clk,
  input  logic                reset,
  input  logic [31:0]         InstrD,
  input  logic [3:0]          ALUFlagsE,
  input  logic                FlushE,
  output pipeCtrlPkg::regSrc  RegSrcD,
  output pipeCtrlPkg::immSrc  ImmSrcD,
  output logic                ALUSrcE,
  output armIsaPkg::aluOp     ALUControlE,
  output logic                BranchTakenE,
  output logic                MemWriteM,
  output logic                MemtoRegE,
  output logic                MemtoRegW,
  output logic                RegWriteM,
  output logic                RegWriteW
);
  import armIsaPkg::*;
  import pipeCtrlPkg::*;

  logic    regWriteD, memWriteD, memtoRegD, aluSrcD, branchD, flagWriteD;
  aluOp    aluControlD;
  logic    regWriteE, memWriteE, branchE, flagWriteE, condExE, memtoRegM;
  condCode condE;
  logic [3:0] flagsReg;

  // Decode op, funct and cond into a control word
  always_comb begin
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    memtoRegD   = 1'b0;
    aluSrcD     = 1'b0;
    branchD     = 1'b0;
    flagWriteD  = 1'b0;
    aluControlD = aluAdd;
    RegSrcD     = 2'b00;
    ImmSrcD     = immRotated;
    case (InstrD[27:26])
      2'b00: begin
        aluSrcD    = InstrD[25];
        flagWriteD = InstrD[20];
        regWriteD  = 1'b1;
        case (dpOpcode'(InstrD[24:21]))
          opAnd: aluControlD = aluAnd;
          opSub: aluControlD = aluSub;
          opAdd: aluControlD = aluAdd;
          opOrr: aluControlD = aluOrr;
          opMov: aluControlD = aluPassB;
          opCmp: begin
            aluControlD = aluSub;
            regWriteD   = 1'b0;
            flagWriteD  = 1'b1;
          end
          default: regWriteD = 1'b0;
        endcase
      end
      2'b01: begin
        aluSrcD = 1'b1;
        ImmSrcD = immOffset12;
        if (InstrD[20]) begin
          regWriteD = 1'b1;
          memtoRegD = 1'b1;
        end else begin
          memWriteD          = 1'b1;
          RegSrcD[RegSrcRdB] = 1'b1;
        end
      end
      2'b10: begin
        // Target is PC+8 plus the shifted offset
        aluSrcD            = 1'b1;
        ImmSrcD            = immBranch24;
        branchD            = 1'b1;
        RegSrcD[RegSrcPcA] = 1'b1;
      end
      default: ;
    endcase
  end

  // Execute-stage control
  always_ff @(posedge clk) begin
    if (reset || FlushE) begin
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      MemtoRegE   <= 1'b0;
      ALUSrcE     <= 1'b0;
      branchE     <= 1'b0;
      flagWriteE  <= 1'b0;
      ALUControlE <= aluAdd;
      condE       <= condEq;
    end else begin
      regWriteE   <= regWriteD;
      memWriteE   <= memWriteD;
      MemtoRegE   <= memtoRegD;
      ALUSrcE     <= aluSrcD;
      branchE     <= branchD;
      flagWriteE  <= flagWriteD;
      ALUControlE <= aluControlD;
      condE       <= condCode'(InstrD[31:28]);
    end
  end

  always_comb begin
    case (condE)
      condEq:  condExE = flagsReg[FlagZ];
      condNe:  condExE = !flagsReg[FlagZ];
      condCs:  condExE = flagsReg[FlagC];
      condCc:  condExE = !flagsReg[FlagC];
      condMi:  condExE = flagsReg[FlagN];
      condPl:  condExE = !flagsReg[FlagN];
      condVs:  condExE = flagsReg[FlagV];
      condVc:  condExE = !flagsReg[FlagV];
      condHi:  condExE = flagsReg[FlagC] && !flagsReg[FlagZ];
      condLs:  condExE = !flagsReg[FlagC] || flagsReg[FlagZ];
      condGe:  condExE = flagsReg[FlagN] == flagsReg[FlagV];
      condLt:  condExE = flagsReg[FlagN] != flagsReg[FlagV];
      condGt:  condExE = !flagsReg[FlagZ] && (flagsReg[FlagN] == flagsReg[FlagV]);
      condLe:  condExE = flagsReg[FlagZ] || (flagsReg[FlagN] != flagsReg[FlagV]);
      condAl:  condExE = 1'b1;
      default: condExE = 1'b0;
    endcase
  end

  assign BranchTakenE = branchE && condExE;

  // N and Z always, C and V only from add and subtract
  always_ff @(posedge clk) begin
    if (reset) begin
      flagsReg <= 4'b0000;
    end else if (flagWriteE && condExE) begin
      flagsReg[FlagN] <= ALUFlagsE[FlagN];
      flagsReg[FlagZ] <= ALUFlagsE[FlagZ];
      if (ALUControlE == aluAdd || ALUControlE == aluSub) begin
        flagsReg[FlagC] <= ALUFlagsE[FlagC];
        flagsReg[FlagV] <= ALUFlagsE[FlagV];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      RegWriteM <= 1'b0;
      MemWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      RegWriteW <= 1'b0;
      MemtoRegW <= 1'b0;
    end else begin
      RegWriteM <= regWriteE && condExE;
      MemWriteM <= memWriteE && condExE;
      memtoRegM <= MemtoRegE;
      RegWriteW <= RegWriteM;
      MemtoRegW <= memtoRegM;
    end
  end

  // A store leaving memory must not turn up as a load in writeback
  storeNotLoad: assert property (@(posedge clk) disable iff (reset) MemWriteM |=> !MemtoRegW)
    else $error("controller: store and load bits set on one instruction");

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        WriteEnable,
  input  logic [3:0]  ReadAddr1,
  input  logic [3:0]  ReadAddr2,
  input  logic [3:0]  WriteAddr,
  input  logic [31:0] WriteData,
  input  logic [31:0] PCPlus8,
  output logic [31:0] ReadData1,
  output logic [31:0] ReadData2
);
  // R0 to R14 only
  logic [31:0] regs [0:14];

  always_ff @(posedge clk) begin
    if (WriteEnable) begin
      regs[WriteAddr] <= WriteData;
    end
  end

  // R15 reads as PC+8, a write in flight is passed straight through
  function automatic logic [31:0] readPort(input logic [3:0] addr);
    if (addr == 4'd15) begin
      return PCPlus8;
    end else if (WriteEnable && addr == WriteAddr) begin
      return WriteData;
    end
    return regs[addr];
  endfunction

  always_comb begin
    ReadData1 = readPort(ReadAddr1);
    ReadData2 = readPort(ReadAddr2);
  end

  noR15Write: assert property (@(posedge clk) WriteEnable |-> WriteAddr != 4'd15)
    else $error("regFile: write to R15");

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic [31:0]     SrcA,
  input  logic [31:0]     SrcB,
  input  armIsaPkg::aluOp ALUControl,
  output logic [31:0]     Result,
  output logic [3:0]      Flags
);
  import armIsaPkg::*;

  logic        isSub, isArith;
  logic [31:0] operandB;
  logic [32:0] sum;

  // Subtract as A + ~B + 1, so carry out means no borrow
  assign isSub    = (ALUControl == aluSub);
  assign isArith  = (ALUControl == aluAdd) || isSub;
  assign operandB = isSub ? ~SrcB : SrcB;
  assign sum      = {1'b0, SrcA} + {1'b0, operandB} + 33'(isSub);

  always_comb begin
    case (ALUControl)
      aluAdd, aluSub: Result = sum[31:0];
      aluAnd:         Result = SrcA & SrcB;
      aluOrr:         Result = SrcA | SrcB;
      default:        Result = SrcB;
    endcase
  end

  assign Flags[FlagN] = Result[31];
  assign Flags[FlagZ] = (Result == 32'b0);
  assign Flags[FlagC] = isArith && sum[32];
  // Inputs agree in sign, sum does not
  assign Flags[FlagV] = isArith && (SrcA[31] == operandB[31]) && (sum[31] != SrcA[31]);

endmodule

/* design/pipeCtrlPkg.sv */
package pipeCtrlPkg;

  // Bypass source for an execute-stage operand
  typedef enum logic [1:0] {
    fwdNone      = 2'b00,
    fwdWriteback = 2'b01,
    fwdMemory    = 2'b10
  } fwdSel;

  typedef enum logic [1:0] {
    immRotated,
    immOffset12,
    immBranch24
  } immSrc;

  // Register source selects, one bit per read port
  typedef logic [1:0] regSrc;

  // R15 as first source (branch)
  localparam int RegSrcPcA = 0;
  // Rd as second source (store data)
  localparam int RegSrcRdB = 1;

endpackage

/* design/armIsaPkg.sv */
package armIsaPkg;

  // Data-processing opcode field, instr[24:21]
  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opSub = 4'b0010,
    opAdd = 4'b0100,
    opCmp = 4'b1010,
    opOrr = 4'b1100,
    opMov = 4'b1101
  } dpOpcode;

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    condEq = 4'b0000, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl
  } condCode;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluPassB
  } aluOp;

  // Bit positions in the NZCV vector
  localparam int FlagN = 3;
  localparam int FlagZ = 2;
  localparam int FlagC = 1;
  localparam int FlagV = 0;

endpackage
